//--- bench/forthCore_chk.sv
// ##############################
// Core protocol checker
// Bound assertions on phase order, memory arbitration
// and the APB response of the debug port.
// ##############################
`default_nettype none

module forthCore_chk (
	input logic CLK,
	input logic rstN,
	input cpuPkg::phase_t phase,
	input cpuPkg::memReq_t coreReq,
	input logic dbgGrant,
	input logic stopped,
	input logic psel,
	input logic penable,
	input logic pready
);
	timeunit 1ns;
	timeprecision 100ps;

	fetchToDecode: assert property (@(posedge CLK) disable iff (!rstN)
		phase == cpuPkg::FETCH |=> phase == cpuPkg::DECODE)
		else $error("FETCH was not followed by DECODE.");

	decodeToExecute: assert property (@(posedge CLK) disable iff (!rstN)
		phase == cpuPkg::DECODE |=> phase == cpuPkg::EXECUTE)
		else $error("DECODE was not followed by EXECUTE.");

	executeToCommit: assert property (@(posedge CLK) disable iff (!rstN)
		phase == cpuPkg::EXECUTE |=> phase == cpuPkg::COMMIT)
		else $error("EXECUTE was not followed by COMMIT.");

	// After COMMIT the core either fetches again or stops.
	commitToNext: assert property (@(posedge CLK) disable iff (!rstN)
		phase == cpuPkg::COMMIT |=> (phase == cpuPkg::FETCH || phase == cpuPkg::STOPPED))
		else $error("COMMIT was followed by an unexpected phase.");

	idleWhileStopped: assert property (@(posedge CLK) disable iff (!rstN)
		stopped |-> !coreReq.en)
		else $error("Core memory request while stopped.");

	grantOnlyWhenCoreIdle: assert property (@(posedge CLK) disable iff (!rstN)
		dbgGrant |-> !coreReq.en)
		else $error("Debug grant together with a core request.");

	readyInAccess: assert property (@(posedge CLK) disable iff (!rstN)
		pready |-> (psel && penable))
		else $error("pready high outside an APB access phase.");

endmodule

bind forthCore forthCore_chk chk0 (
	.CLK(CLK), .rstN(rstN), .phase(phase), .coreReq(coreReq), .dbgGrant(dbgGrant),
	.stopped(stopped), .psel(psel), .penable(penable), .pready(pready)
);

`default_nettype wire

//--- bench/forthCore_tb.sv
// ##############################
// Forth core testbench
// Loads random programs over APB, runs and steps them,
// and compares the core with an instruction-set model.
// ##############################
`default_nettype none
`include "cpu_params.svh"

module forthCore_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int cycleLimit = 200000;   // Tests need well under 20000 cycles.

	logic CLK;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] paddr;
	cpuPkg::word_t pwdata;
	cpuPkg::word_t prdata;
	logic pready;
	logic stopped;

	cpuPkg::word_t image [256];   // Program and data as loaded into the DUT.
	cpuPkg::word_t mMem [256];    // Model memory.
	cpuPkg::word_t mRegs [8];
	logic mZero;
	logic [7:0] mPc;
	logic mHalted;
	logic [31:0] rngState = 32'd23;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int testErrors = 0;

	forthCore dut0 (
		.CLK(CLK), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .stopped(stopped)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Run timed out after %0d cycles before the tests finished.", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] nextRand();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	function automatic cpuPkg::word_t encodeReg(input logic [3:0] op, input logic [2:0] rd,
			input logic [2:0] ra, input logic [2:0] rb);
		return {op, rd, ra, rb, 3'b000};
	endfunction

	function automatic cpuPkg::word_t encodeImm(input logic [3:0] op, input logic [2:0] rd,
			input logic [7:0] imm);
		return {op, rd, 1'b0, imm};
	endfunction

	task automatic resetDut();
		rstN <= 1'b0;
		repeat (3) @(posedge CLK);
		rstN <= 1'b1;
		for (int r = 0; r < 8; r++) mRegs[r] = '0;
		mZero = 1'b0;
		mPc = '0;
		mHalted = 1'b0;
	endtask

	// Setup cycle, then access cycles until pready, sampled on the falling edge.
	task automatic apbAccess(input logic write, input logic [3:0] addr,
			input cpuPkg::word_t wdata, output cpuPkg::word_t rdata);
		@(posedge CLK);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge CLK);
		penable <= 1'b1;
		@(negedge CLK);
		while (!pready) @(negedge CLK);
		rdata = prdata;
		@(posedge CLK);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apbWrite(input logic [3:0] addr, input cpuPkg::word_t data);
		cpuPkg::word_t unused;
		apbAccess(1'b1, addr, data, unused);
	endtask

	task automatic apbRead(input logic [3:0] addr, output cpuPkg::word_t data);
		apbAccess(1'b0, addr, '0, data);
	endtask

	task automatic checkEq(input string what, input int idx, input cpuPkg::word_t got,
			input cpuPkg::word_t exp);
		checks++;
		assert (got === exp) else begin
			$display("Error at %0t: %s %0d read %h, expected %h", $time, what, idx, got, exp);
			testErrors++;
		end
	endtask

	task automatic finishTest(input int num, input string name);
		$display("Test %0d %s finished with %0d errors.", num, name, testErrors);
		errors += testErrors;
		testErrors = 0;
	endtask

	// One instruction of the model, following the instruction-set rules.
	task automatic modelStep();
		cpuPkg::word_t ins;
		cpuPkg::word_t a;
		cpuPkg::word_t b;
		logic [2:0] rd;
		logic [7:0] imm;
		logic [7:0] nextPc;
		ins = mMem[mPc];
		rd = ins[11:9];
		imm = ins[7:0];
		a = mRegs[ins[8:6]];
		b = mRegs[ins[5:3]];
		nextPc = mPc + 8'd1;
		case (ins[15:12])
			cpuPkg::ADD: mRegs[rd] = a + b;
			cpuPkg::SUB: mRegs[rd] = a - b;
			cpuPkg::AND: mRegs[rd] = a & b;
			cpuPkg::OR:  mRegs[rd] = a | b;
			cpuPkg::XOR: mRegs[rd] = a ^ b;
			cpuPkg::LDI: mRegs[rd] = {8'h00, imm};
			cpuPkg::LD:  mRegs[rd] = mMem[a[7:0]];
			cpuPkg::ST:  mMem[a[7:0]] = mRegs[rd];
			cpuPkg::JZ:  nextPc = mZero ? imm : nextPc;
			cpuPkg::JMP: nextPc = imm;
			cpuPkg::HALT: mHalted = 1'b1;
			default: ;
		endcase
		if (ins[15:12] >= 4'h1 && ins[15:12] <= 4'h5) mZero = (mRegs[rd] == '0);
		mPc = nextPc;
	endtask

	task automatic modelRun();
		int guard;
		guard = 0;
		while (!mHalted && guard < 10000) begin
			modelStep();
			guard++;
		end
	endtask

	// Forward jumps only, so every program reaches its HALT.
	// A jump never lands between an address load and its memory access.
	task automatic genProgram(input int len);
		int i;
		logic [31:0] kind;
		logic [2:0] ra;
		logic [3:0] op;
		logic [255:0] pairTail;   // Marks the LD or ST half of each pair.
		pairTail = '0;
		for (int a = 0; a < 128; a++) image[a] = '0;
		for (int a = 128; a < 256; a++) image[a] = nextRand();
		i = 0;
		while (i < len - 1) begin
			kind = nextRand() % 8;
			if (kind == 5 && i < len - 3) begin
				ra = nextRand();
				image[i] = encodeImm(cpuPkg::LDI, ra, 8'h80 | nextRand());   // Data region.
				op = (nextRand() % 2) ? cpuPkg::LD : cpuPkg::ST;
				image[i + 1] = encodeReg(op, nextRand(), ra, 3'd0);
				pairTail[i + 1] = 1'b1;
				i += 2;
			end else if (kind >= 6) begin
				op = (kind == 6) ? cpuPkg::JZ : cpuPkg::JMP;
				image[i] = encodeImm(op, 3'd0, i + 1 + nextRand() % (len - 1 - i));
				i++;
			end else if (kind == 4) begin
				image[i] = encodeImm(cpuPkg::LDI, nextRand(), nextRand());
				i++;
			end else begin
				op = 4'd1 + nextRand() % 5;
				image[i] = encodeReg(op, nextRand(), nextRand(), nextRand());
				i++;
			end
		end
		image[len - 1] = encodeImm(cpuPkg::HALT, 3'd0, 8'd0);
		for (int j = 0; j < len - 1; j++) begin
			op = image[j][15:12];
			if ((op == cpuPkg::JZ || op == cpuPkg::JMP) && pairTail[image[j][7:0]]) begin
				image[j] = {image[j][15:8], image[j][7:0] + 8'd1};   // Next instruction.
			end
		end
	endtask

	// Countdown in r1; the body stores only to word 128.
	task automatic genLoopProgram();
		for (int a = 0; a < 128; a++) image[a] = '0;
		for (int a = 128; a < 256; a++) image[a] = nextRand();
		image[0] = encodeImm(cpuPkg::LDI, 3'd1, 8'd20 + nextRand() % 20);
		image[1] = encodeImm(cpuPkg::LDI, 3'd2, 8'd1);
		image[2] = encodeImm(cpuPkg::LDI, 3'd7, 8'd128);
		image[3] = encodeReg(cpuPkg::SUB, 3'd1, 3'd1, 3'd2);
		image[4] = encodeImm(cpuPkg::JZ, 3'd0, 8'd10);
		for (int k = 5; k < 8; k++) begin
			image[k] = encodeReg(4'd1 + nextRand() % 5, 3'd3 + nextRand() % 4,
				nextRand(), nextRand());
		end
		image[8] = encodeReg(cpuPkg::ST, 3'd3, 3'd7, 3'd0);
		image[9] = encodeImm(cpuPkg::JMP, 3'd0, 8'd3);
		image[10] = encodeImm(cpuPkg::HALT, 3'd0, 8'd0);
	endtask

	task automatic loadImage();
		apbWrite(`DBG_MADDR, 16'd0);
		for (int a = 0; a < 256; a++) begin
			apbWrite(`DBG_MDATA, image[a]);
			mMem[a] = image[a];
		end
	endtask

	task automatic waitStopped();
		cpuPkg::word_t v;
		v = '0;
		while (!v[0]) apbRead(`DBG_CTRL, v);
	endtask

	task automatic checkState(input logic withData);
		cpuPkg::word_t v;
		@(negedge CLK);
		checkEq("stopped output", 0, {15'h0000, stopped}, 16'h1);
		for (int r = 0; r < 8; r++) begin
			apbRead(`DBG_REG0 + r, v);
			checkEq("register", r, v, mRegs[r]);
		end
		apbRead(`DBG_PC, v);
		checkEq("pc", 0, v, {8'h00, mPc});
		if (withData) begin
			apbWrite(`DBG_MADDR, 16'd128);
			for (int a = 128; a < 256; a++) begin
				apbRead(`DBG_MDATA, v);
				checkEq("data word", a, v, mMem[a]);
			end
		end
	endtask

	initial begin
		cpuPkg::word_t v;
		cpuPkg::word_t written [32];
		logic [7:0] start;
		int steps;
		$timeformat(-9, 0, " ns", 0);
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		resetDut();

		apbRead(`DBG_CTRL, v);
		checkEq("stopped flag", 0, v & 16'h1, 16'h1);
		checkState(1'b0);
		finishTest(1, "reset state");

		start = nextRand();
		apbWrite(`DBG_MADDR, start);
		for (int i = 0; i < 32; i++) begin
			written[i] = nextRand();
			apbWrite(`DBG_MDATA, written[i]);
		end
		apbRead(`DBG_MADDR, v);
		checkEq("address after writes", 0, v, {8'h00, start + 8'd32});
		apbWrite(`DBG_MADDR, start);
		for (int i = 0; i < 32; i++) begin
			apbRead(`DBG_MDATA, v);
			checkEq("memory word", start + i, v, written[i]);
		end
		finishTest(2, "debug memory access");

		for (int p = 0; p < 3; p++) begin
			resetDut();
			genProgram(40 + nextRand() % 60);
			loadImage();
			apbWrite(`DBG_CTRL, 16'h1);
			waitStopped();
			modelRun();
			checkState(1'b1);
		end
		finishTest(3, "random program run");

		resetDut();
		genProgram(24);
		loadImage();
		steps = 0;
		while (!mHalted && steps < 200) begin
			apbWrite(`DBG_CTRL, 16'h2);
			waitStopped();
			modelStep();
			checkState(1'b0);
			steps++;
		end
		checkState(1'b1);
		finishTest(4, "single step");

		resetDut();
		genLoopProgram();
		loadImage();
		apbWrite(`DBG_CTRL, 16'h1);
		apbWrite(`DBG_MADDR, 16'd200);
		@(negedge CLK);
		checkEq("stopped output while running", 0, {15'h0000, stopped}, 16'h0);
		for (int i = 0; i < 16; i++) begin
			apbRead(`DBG_MDATA, v);
			checkEq("data word while running", 200 + i, v, image[200 + i]);
		end
		waitStopped();
		modelRun();
		checkState(1'b1);
		finishTest(5, "debug reads during loop");

		$display("Summary: 5 tests, %0d checks, %0d errors.", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- forthCore.f
+incdir+hw
hw/cpuPkg.sv
hw/instructionSequencer.sv
hw/instructionDecoder.sv
hw/registerFile.sv
hw/executeUnit.sv
hw/busArbiter.sv
hw/debugPort.sv
hw/wordMemory.sv
hw/forthCore.sv
bench/forthCore_chk.sv
bench/forthCore_tb.sv

//--- hw/busArbiter.sv
// ##############################
// Bus arbiter
// Shares the memory between core and debug port, with the
// core always first.
// ##############################
`default_nettype none

module busArbiter (
	input  logic CLK,
	input  logic rstN,
	input  cpuPkg::memReq_t coreReq,
	input  cpuPkg::memReq_t dbgReq,
	input  cpuPkg::word_t memRdata,
	output cpuPkg::memReq_t memReq,
	output logic dbgGrant,
	output logic dbgRvalid,
	output cpuPkg::word_t rdata
);

	logic dbgReadGranted;   // Debug read went to memory in the last cycle.

	// The core never waits, so its request always passes.
	assign dbgGrant = dbgReq.en && !coreReq.en;
	assign memReq = coreReq.en ? coreReq : dbgReq;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			dbgReadGranted <= 1'b0;
		end else begin
			dbgReadGranted <= dbgGrant && !dbgReq.we;
		end
	end

	assign dbgRvalid = dbgReadGranted;
	assign rdata = memRdata;   // Read data returns to both sides. The owner knows its cycle.

endmodule

`default_nettype wire

//--- hw/cpuPkg.sv
// ##############################
// CPU package
// Shared types of the core: data words, addresses, opcodes,
// phases, decoded control and memory requests.
// ##############################
`default_nettype none
`include "cpu_params.svh"

package cpuPkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`MEM_AW-1:0] memAddr_t;       // Also the width of the PC.
	typedef logic [$clog2(`REG_N)-1:0] regIdx_t;

	// Zero decodes as NOP, so cleared memory runs harmlessly.
	typedef enum logic [3:0] {
		NOP  = 4'h0,
		ADD  = 4'h1,
		SUB  = 4'h2,
		AND  = 4'h3,
		OR   = 4'h4,
		XOR  = 4'h5,
		LDI  = 4'h6,
		LD   = 4'h7,
		ST   = 4'h8,
		JZ   = 4'h9,
		JMP  = 4'hA,
		HALT = 4'hF
	} opcode_t;

	typedef enum logic [2:0] {STOPPED, FETCH, DECODE, EXECUTE, COMMIT} phase_t;

	typedef struct packed {
		opcode_t opcode;
		regIdx_t rd;
		regIdx_t ra;
		regIdx_t rb;
		logic [7:0] imm8;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic flagWrite;
		logic jump;     // Set for both JMP and JZ.
		logic halt;
	} ctrl_t;

	typedef struct packed {
		logic en;
		logic we;
		memAddr_t addr;
		word_t wdata;
	} memReq_t;

endpackage

`default_nettype wire

//--- hw/cpu_params.svh
// ##############################
// CPU parameters
// Word, memory and register sizes of the core, and the
// APB register map of the debug port.
// ##############################
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define WORD_W    16    // Width of a data word and of an instruction.
`define MEM_AW    8     // Memory address width, which is also the PC width.
`define REG_N     8     // Number of general registers.

// Debug port word offsets.
`define DBG_CTRL  4'd0  // Run and step on write, stopped flag on read.
`define DBG_MADDR 4'd1  // Debug memory address.
`define DBG_MDATA 4'd2  // Memory data at DBG_MADDR.
`define DBG_REG0  4'd4  // First of eight register windows.
`define DBG_PC    4'd12 // Program counter window.

`endif

//--- hw/debugPort.sv
// ##############################
// Debug port
// APB slave giving run and step control, register and PC
// readback, and memory access with auto-increment.
// ##############################
`default_nettype none
`include "cpu_params.svh"

module debugPort (
	input  logic CLK,
	input  logic rstN,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [3:0] paddr,
	input  cpuPkg::word_t pwdata,
	output cpuPkg::word_t prdata,
	output logic pready,
	input  logic stopped,
	input  cpuPkg::memAddr_t pc,
	input  cpuPkg::word_t regData,
	input  logic memGrant,
	input  logic memRvalid,
	input  cpuPkg::word_t memRdata,
	output cpuPkg::memReq_t memReq,
	output cpuPkg::regIdx_t regSel,
	output logic run,
	output logic step
);

	logic access;              // APB access phase.
	logic mdataSel;
	logic ctrlWrite;
	logic readWait;            // A granted read waits for its data.
	logic [3:0] regOffset;
	cpuPkg::memAddr_t maddr;

	assign access = psel && penable;
	assign mdataSel = (paddr == `DBG_MDATA);
	assign ctrlWrite = access && pwrite && (paddr == `DBG_CTRL);
	assign regOffset = paddr - `DBG_REG0;
	assign regSel = regOffset[2:0];

	// The request stays up until the arbiter grants it.
	always_comb begin
		memReq.en = access && mdataSel && !readWait;
		memReq.we = pwrite;
		memReq.addr = maddr;
		memReq.wdata = pwdata;
	end

	always_comb begin
		if (!mdataSel) begin
			pready = access;   // Registers answer in the first access cycle.
		end else if (pwrite) begin
			pready = access && memGrant;
		end else begin
			pready = access && readWait && memRvalid;
		end
	end

	always_comb begin
		prdata = '0;
		if (paddr == `DBG_CTRL) begin
			prdata[0] = stopped;
		end else if (paddr == `DBG_MADDR) begin
			prdata[`MEM_AW-1:0] = maddr;
		end else if (mdataSel) begin
			prdata = memRdata;
		end else if (paddr >= `DBG_REG0 && paddr < `DBG_PC) begin
			prdata = regData;
		end else if (paddr == `DBG_PC) begin
			prdata[`MEM_AW-1:0] = pc;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			run <= 1'b0;
			step <= 1'b0;
			readWait <= 1'b0;
			maddr <= '0;
		end else begin
			run <= ctrlWrite && pwdata[0];
			step <= ctrlWrite && pwdata[1];
			if (memReq.en && !pwrite && memGrant) begin
				readWait <= 1'b1;
			end else if (memRvalid) begin
				readWait <= 1'b0;
			end
			if (access && pwrite && paddr == `DBG_MADDR) begin
				maddr <= pwdata[`MEM_AW-1:0];
			end else if (pready && mdataSel) begin
				maddr <= maddr + 1'b1;   // Auto-increment after each data access.
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/executeUnit.sv
// ##############################
// Execute unit
// ALU, zero flag, write-back selection and the core's
// memory requests for fetch, load and store.
// ##############################
`default_nettype none
`include "cpu_params.svh"

module executeUnit (
	input  logic CLK,
	input  logic rstN,
	input  cpuPkg::phase_t phase,
	input  cpuPkg::memAddr_t pc,
	input  cpuPkg::ctrl_t ctrl,
	input  cpuPkg::word_t opA,
	input  cpuPkg::word_t opB,
	input  cpuPkg::word_t memRdata,
	output cpuPkg::memReq_t memReq,
	output logic regWe,
	output cpuPkg::word_t regWdata,
	output logic zero
);

	cpuPkg::word_t aluResult;
	logic commit;

	assign commit = (phase == cpuPkg::COMMIT);

	always_comb begin
		case (ctrl.opcode)
			cpuPkg::ADD: aluResult = opA + opB;
			cpuPkg::SUB: aluResult = opA - opB;
			cpuPkg::AND: aluResult = opA & opB;
			cpuPkg::OR:  aluResult = opA | opB;
			cpuPkg::XOR: aluResult = opA ^ opB;
			default:     aluResult = '0;
		endcase
	end

	// Load data is on memRdata during COMMIT.
	always_comb begin
		case (ctrl.opcode)
			cpuPkg::LDI: regWdata = {{(`WORD_W-8){1'b0}}, ctrl.imm8};
			cpuPkg::LD:  regWdata = memRdata;
			default:     regWdata = aluResult;
		endcase
	end

	assign regWe = commit && ctrl.regWrite;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			zero <= 1'b0;
		end else if (commit && ctrl.flagWrite) begin
			zero <= (aluResult == '0);
		end
	end

	always_comb begin
		memReq.en = (phase == cpuPkg::FETCH);   // Instruction fetch at the PC.
		memReq.we = 1'b0;
		memReq.addr = pc;
		memReq.wdata = opB;
		if (phase == cpuPkg::EXECUTE) begin
			memReq.en = ctrl.memRead || ctrl.memWrite;
			memReq.we = ctrl.memWrite;
			memReq.addr = opA[`MEM_AW-1:0];
		end
	end

endmodule

`default_nettype wire

//--- hw/forthCore.sv
// ##############################
// Forth CPU core
// Sequencer, decoder, registers, execute unit, debug port,
// arbiter and memory joined together.
// ##############################
`default_nettype none

module forthCore (
	input  logic CLK,
	input  logic rstN,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [3:0] paddr,
	input  cpuPkg::word_t pwdata,
	output cpuPkg::word_t prdata,
	output logic pready,
	output logic stopped
);

	cpuPkg::phase_t phase;
	cpuPkg::memAddr_t pc;
	cpuPkg::ctrl_t ctrl;
	logic zero;
	logic run;
	logic step;
	logic regWe;
	cpuPkg::word_t regWdata;
	cpuPkg::word_t opA;
	cpuPkg::word_t opB;
	cpuPkg::word_t regData;
	cpuPkg::regIdx_t regSel;
	cpuPkg::memReq_t coreReq;
	cpuPkg::memReq_t dbgReq;
	cpuPkg::memReq_t memReq;
	cpuPkg::word_t memRdata;
	cpuPkg::word_t rdata;      // Memory read data as returned by the arbiter.
	logic dbgGrant;
	logic dbgRvalid;

	instructionSequencer seq0 (
		.CLK(CLK), .rstN(rstN), .run(run), .step(step), .zero(zero),
		.instr(ctrl), .phase(phase), .pc(pc), .stopped(stopped)
	);

	instructionDecoder dec0 (
		.CLK(CLK), .rstN(rstN), .phase(phase), .rdata(rdata), .ctrl(ctrl)
	);

	registerFile regs0 (
		.CLK(CLK), .rstN(rstN), .we(regWe), .waddr(ctrl.rd), .wdata(regWdata),
		.raddrA(ctrl.ra), .raddrB(ctrl.rb), .raddrDbg(regSel),
		.rdataA(opA), .rdataB(opB), .rdataDbg(regData)
	);

	executeUnit exe0 (
		.CLK(CLK), .rstN(rstN), .phase(phase), .pc(pc), .ctrl(ctrl),
		.opA(opA), .opB(opB), .memRdata(rdata), .memReq(coreReq),
		.regWe(regWe), .regWdata(regWdata), .zero(zero)
	);

	busArbiter arb0 (
		.CLK(CLK), .rstN(rstN), .coreReq(coreReq), .dbgReq(dbgReq),
		.memRdata(memRdata), .memReq(memReq), .dbgGrant(dbgGrant),
		.dbgRvalid(dbgRvalid), .rdata(rdata)
	);

	debugPort dbg0 (
		.CLK(CLK), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.stopped(stopped), .pc(pc), .regData(regData), .memGrant(dbgGrant),
		.memRvalid(dbgRvalid), .memRdata(rdata), .memReq(dbgReq),
		.regSel(regSel), .run(run), .step(step)
	);

	wordMemory mem0 (
		.CLK(CLK), .req(memReq), .rdata(memRdata)
	);

endmodule

`default_nettype wire

//--- hw/instructionDecoder.sv
// ##############################
// Instruction decoder
// Holds the fetched word and turns it into the control
// struct used in EXECUTE and COMMIT.
// ##############################
`default_nettype none

module instructionDecoder (
	input  logic CLK,
	input  logic rstN,
	input  cpuPkg::phase_t phase,
	input  cpuPkg::word_t rdata,
	output cpuPkg::ctrl_t ctrl
);

	cpuPkg::word_t ir;     // Instruction register.
	cpuPkg::opcode_t op;

	// Fetch data arrives one cycle after the request, in DECODE.
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			ir <= '0;
		end else if (phase == cpuPkg::DECODE) begin
			ir <= rdata;
		end
	end

	assign op = cpuPkg::opcode_t'(ir[15:12]);

	always_comb begin
		ctrl = '0;
		ctrl.opcode = cpuPkg::NOP;   // Unknown opcodes stay NOP.
		ctrl.rd = ir[11:9];
		ctrl.ra = ir[8:6];
		ctrl.rb = ir[5:3];
		ctrl.imm8 = ir[7:0];
		case (op)
			cpuPkg::ADD, cpuPkg::SUB, cpuPkg::AND, cpuPkg::OR, cpuPkg::XOR: begin
				ctrl.opcode = op;
				ctrl.regWrite = 1'b1;
				ctrl.flagWrite = 1'b1;
			end
			cpuPkg::LDI: begin
				ctrl.opcode = op;
				ctrl.regWrite = 1'b1;
			end
			cpuPkg::LD: begin
				ctrl.opcode = op;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
			end
			cpuPkg::ST: begin
				ctrl.opcode = op;
				ctrl.memWrite = 1'b1;
				ctrl.rb = ir[11:9];   // Store data is read through the B port.
			end
			cpuPkg::JZ, cpuPkg::JMP: begin
				ctrl.opcode = op;
				ctrl.jump = 1'b1;
			end
			cpuPkg::HALT: begin
				ctrl.opcode = op;
				ctrl.halt = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/instructionSequencer.sv
// ##############################
// Instruction sequencer
// Steps the four instruction phases, handles run and
// single-step, and keeps the program counter.
// ##############################
`default_nettype none

module instructionSequencer (
	input  logic CLK,
	input  logic rstN,
	input  logic run,
	input  logic step,
	input  logic zero,
	input  cpuPkg::ctrl_t instr,
	output cpuPkg::phase_t phase,
	output cpuPkg::memAddr_t pc,
	output logic stopped
);

	logic stepping;   // One instruction is running under a step request.
	logic jumpTaken;

	assign stopped = (phase == cpuPkg::STOPPED);
	assign jumpTaken = instr.jump && ((instr.opcode == cpuPkg::JMP) || zero);

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			phase <= cpuPkg::STOPPED;
			pc <= '0;
			stepping <= 1'b0;
		end else begin
			case (phase)
				cpuPkg::STOPPED: begin
					if (run || step) begin
						phase <= cpuPkg::FETCH;
						stepping <= step && !run;   // A run request wins over a step.
					end
				end
				cpuPkg::FETCH:   phase <= cpuPkg::DECODE;
				cpuPkg::DECODE:  phase <= cpuPkg::EXECUTE;
				cpuPkg::EXECUTE: phase <= cpuPkg::COMMIT;
				cpuPkg::COMMIT: begin
					pc <= jumpTaken ? instr.imm8 : pc + 1'b1;   // Wraps at the top of memory.
					if (instr.halt || stepping) begin
						phase <= cpuPkg::STOPPED;
						stepping <= 1'b0;
					end else begin
						phase <= cpuPkg::FETCH;
					end
				end
				default: phase <= cpuPkg::STOPPED;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/registerFile.sv
// ##############################
// Register file
// Eight general registers, two operand read ports, one
// debug read port and one write port.
// ##############################
`default_nettype none
`include "cpu_params.svh"

module registerFile (
	input  logic CLK,
	input  logic rstN,
	input  logic we,
	input  cpuPkg::regIdx_t waddr,
	input  cpuPkg::word_t wdata,
	input  cpuPkg::regIdx_t raddrA,
	input  cpuPkg::regIdx_t raddrB,
	input  cpuPkg::regIdx_t raddrDbg,
	output cpuPkg::word_t rdataA,
	output cpuPkg::word_t rdataB,
	output cpuPkg::word_t rdataDbg
);

	cpuPkg::word_t regs [`REG_N];

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdataA = regs[raddrA];
	assign rdataB = regs[raddrB];
	assign rdataDbg = regs[raddrDbg];   // Feeds the debug register windows.

endmodule

`default_nettype wire

//--- hw/wordMemory.sv
// ##############################
// Word memory
// Single-port 256 by 16 memory with synchronous write and
// a registered one-cycle read.
// ##############################
`default_nettype none
`include "cpu_params.svh"

module wordMemory (
	input  logic CLK,
	input  cpuPkg::memReq_t req,
	output cpuPkg::word_t rdata
);

	cpuPkg::word_t mem [2**`MEM_AW];   // Program and data share this array.

	// Read data only changes on an enabled read, so it holds between requests.
	always_ff @(posedge CLK) begin
		if (req.en) begin
			if (req.we) begin
				mem[req.addr] <= req.wdata;
			end else begin
				rdata <= mem[req.addr];
			end
		end
	end

endmodule

`default_nettype wire
